// ==== cache.f ====
+incdir+verilog
+incdir+test
verilog/cache_pkg.sv
verilog/cache_way_store.sv
verilog/cache_hit_select.sv
verilog/cache_refill_buffer.sv
verilog/cache_ctrl.sv
verilog/cache.sv
test/cache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module cache_tb \
    -f cache.f -o cache_sim

./obj_dir/cache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
grep -q "test passed" sim.log

// ==== test/cache_tb_tasks.svh ====
`ifndef CACHE_TB_TASKS_SVH
`define CACHE_TB_TASKS_SVH

task automatic check(input logic [255:0] actual, input logic [255:0] expected,
                     input string msg);
    if (actual !== expected) begin
        errors++;
        $display("FAIL %0t: %s got %h expected %h", $time, msg, actual, expected);
    end
endtask

// galois lfsr stepped once per bit
function automatic logic lfsr_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
        lfsr = lfsr ^ 16'hB400;
    end
    return b;
endfunction

function automatic logic [31:0] mem_read(input logic [29:0] idx);
    if (mem_words.exists(idx)) begin
        return mem_words[idx];
    end
    return {2'b00, idx} ^ MEM_PATTERN;
endfunction

function automatic logic [31:0] ref_word(input logic [31:0] addr);
    if (ref_mem.exists(addr[31:2])) begin
        return ref_mem[addr[31:2]];
    end
    return {2'b00, addr[31:2]} ^ MEM_PATTERN;
endfunction

function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [3:0] strb,
                                            input logic [31:0] data);
    logic [31:0] w;
    w = old;
    for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
            w[b*8 +: 8] = data[b*8 +: 8];
        end
    end
    return w;
endfunction

task automatic serve_read();
    mem_rd_req_t r;
    int          n;
    int          d;
    r = rd;
    n = (r.xtype == XFER_LINE) ? 8 : 1;
    rd_count++;
    last_rd = r;
    d = int'({lfsr_bit(), lfsr_bit()});
    repeat (d) @(posedge clk);
    @(posedge clk) rd_rdy <= 1'b1;
    @(posedge clk) rd_rdy <= 1'b0;
    for (int i = 0; i < n; i++) begin
        ret_valid <= 1'b1;
        ret_data  <= mem_read(r.addr[31:2] + 30'(i));
        ret_last  <= (i == n - 1);
        @(posedge clk);
    end
    ret_valid <= 1'b0;
    ret_last  <= 1'b0;
endtask

task automatic serve_write();
    mem_wr_req_t w;
    int          d;
    w = wr;
    wr_count++;
    last_wr = w;
    d = int'({lfsr_bit(), lfsr_bit()});
    repeat (d) @(posedge clk);
    @(posedge clk) wr_rdy <= 1'b1;
    if (w.xtype == XFER_LINE) begin
        for (int i = 0; i < 8; i++) begin
            mem_words[w.addr[31:2] + 30'(i)] = w.data[i*32 +: 32];
        end
    end else begin
        mem_words[w.addr[31:2]] = merge_bytes(mem_read(w.addr[31:2]), w.wstrb, w.data[31:0]);
    end
    @(posedge clk) wr_rdy <= 1'b0;
endtask

// one cpu request returning read data and cycles from accept to data_ok
task automatic cpu_access(input logic wr_op, input logic unc, input logic [1:0] size,
                          input logic [31:0] addr, input logic [3:0] strb,
                          input logic [31:0] wdata, output logic [31:0] data, output int lat);
    cpu_req_t r;
    r.op       = wr_op ? OP_WRITE : OP_READ;
    r.uncached = unc;
    r.size     = size;
    r.tag      = addr[31:12];
    r.index    = addr[11:5];
    r.offset   = addr[4:0];
    r.wstrb    = strb;
    r.wdata    = wdata;
    @(posedge clk);
    valid <= 1'b1;
    req   <= r;
    @(negedge clk);
    while (!addr_ok) @(negedge clk);
    @(posedge clk) valid <= 1'b0;
    lat = 0;
    do begin
        @(negedge clk);
        lat++;
    end while (!data_ok);
    data = rdata;
endtask

task automatic reset_outputs();
    repeat (15) begin
        @(negedge clk);
        check(256'(rd_req), 256'(0), "rd_req in reset");
        check(256'(wr_req), 256'(0), "wr_req in reset");
        check(256'(data_ok), 256'(0), "data_ok in reset");
    end
    @(posedge clk) resetn <= 1'b1;
    @(negedge clk);
    check(256'(addr_ok), 256'(1), "addr_ok after reset");
    check(256'(rd_req | wr_req | data_ok), 256'(0), "idle outputs after reset");
endtask

task automatic read_miss_then_hit();
    logic [31:0] data;
    int          lat;
    int          rd0;
    rd0 = rd_count;
    cpu_access(1'b0, 1'b0, 2'b10, 32'h0001_2044, 4'b0000, 32'h0, data, lat);
    rr_ptr = ~rr_ptr;
    check(256'(rd_count - rd0), 256'(1), "first read misses");
    check(256'(last_rd.xtype), 256'(XFER_LINE), "miss transfer type");
    check(256'(last_rd.addr), 256'(32'h0001_2040), "miss line address");
    check(256'(data), 256'(ref_word(32'h0001_2044)), "miss read data");
    rd0 = rd_count;
    cpu_access(1'b0, 1'b0, 2'b10, 32'h0001_2058, 4'b0000, 32'h0, data, lat);
    check(256'(rd_count - rd0), 256'(0), "hit issues no read");
    check(256'(lat), 256'(1), "hit latency");
    check(256'(data), 256'(ref_word(32'h0001_2058)), "hit read data");
endtask

task automatic write_hit_merge();
    logic [31:0] data;
    int          lat;
    int          rd0;
    int          wr0;
    rd0 = rd_count;
    wr0 = wr_count;
    cpu_access(1'b1, 1'b0, 2'b10, 32'h0001_2048, 4'b0101, 32'hDEAD_BEEF, data, lat);
    ref_mem[30'h0001_2048 >> 2] = merge_bytes(ref_word(32'h0001_2048), 4'b0101, 32'hDEAD_BEEF);
    check(256'(lat), 256'(1), "write hit latency");
    cpu_access(1'b0, 1'b0, 2'b10, 32'h0001_2048, 4'b0000, 32'h0, data, lat);
    check(256'(data), 256'(ref_word(32'h0001_2048)), "merged word");
    check(256'(rd_count - rd0), 256'(0), "write hit reads no memory");
    check(256'(wr_count - wr0), 256'(0), "write hit writes no memory");
endtask

// three tags on set 9 with the first one made dirty
task automatic dirty_eviction();
    logic [31:0]  data;
    logic [255:0] exp_line;
    int           lat;
    int           wr0;
    logic         way_a;
    cpu_access(1'b0, 1'b0, 2'b10, 32'h0003_0120, 4'b0000, 32'h0, data, lat);
    way_a  = rr_ptr;
    rr_ptr = ~rr_ptr;
    cpu_access(1'b1, 1'b0, 2'b10, 32'h0003_0124, 4'b1111, 32'hCAFE_F00D, data, lat);
    ref_mem[30'h0003_0124 >> 2] = 32'hCAFE_F00D;
    cpu_access(1'b0, 1'b0, 2'b10, 32'h0004_0120, 4'b0000, 32'h0, data, lat);
    rr_ptr = ~rr_ptr;
    for (int i = 0; i < 8; i++) begin
        exp_line[i*32 +: 32] = ref_word(32'h0003_0120 + 32'(i * 4));
    end
    wr0 = wr_count;
    cpu_access(1'b0, 1'b0, 2'b10, 32'h0005_0128, 4'b0000, 32'h0, data, lat);
    // the round-robin victim is the dirty way
    check(256'(wr_count - wr0), 256'(rr_ptr == way_a), "dirty victim written back");
    rr_ptr = ~rr_ptr;
    check(256'(last_wr.xtype), 256'(XFER_LINE), "write-back type");
    check(256'(last_wr.addr), 256'(32'h0003_0120), "write-back address");
    check(256'(last_wr.wstrb), 256'(4'b1111), "write-back strobe");
    check(last_wr.data, exp_line, "write-back line");
    check(256'(data), 256'(ref_word(32'h0005_0128)), "read after eviction");
    // now the clean line of the second tag is the victim
    wr0 = wr_count;
    cpu_access(1'b0, 1'b0, 2'b10, 32'h0003_0124, 4'b0000, 32'h0, data, lat);
    rr_ptr = ~rr_ptr;
    check(256'(wr_count - wr0), 256'(0), "clean victim not written");
    check(256'(data), 256'(32'hCAFE_F00D), "refetched dirty data");
endtask

task automatic uncached_access();
    logic [31:0] data;
    int          lat;
    int          rd0;
    cpu_access(1'b0, 1'b1, 2'b10, 32'h0006_0344, 4'b0000, 32'h0, data, lat);
    check(256'(last_rd.xtype), 256'(XFER_WORD), "uncached read type");
    check(256'(last_rd.addr), 256'(32'h0006_0344), "uncached read address");
    check(256'(data), 256'(ref_word(32'h0006_0344)), "uncached read data");
    cpu_access(1'b1, 1'b1, 2'b10, 32'h0007_0364, 4'b0110, 32'h1122_3344, data, lat);
    ref_mem[30'h0007_0364 >> 2] = merge_bytes(ref_word(32'h0007_0364), 4'b0110, 32'h1122_3344);
    check(256'(last_wr.xtype), 256'(XFER_WORD), "uncached write type");
    check(256'(last_wr.addr), 256'(32'h0007_0364), "uncached write address");
    check(256'(last_wr.wstrb), 256'(4'b0110), "uncached write strobe");
    check(256'(last_wr.data[31:0]), 256'(32'h1122_3344), "uncached write data");
    rd0 = rd_count;
    cpu_access(1'b0, 1'b0, 2'b10, 32'h0007_0364, 4'b0000, 32'h0, data, lat);
    rr_ptr = ~rr_ptr;
    check(256'(rd_count - rd0), 256'(1), "cached read after uncached write misses");
    check(256'(data), 256'(ref_word(32'h0007_0364)), "data after uncached write");
endtask

`endif

// ==== test/cache_tb.sv ====
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_tb;
    import cache_pkg::*;

    // longest test sequence stays well under this
    localparam int MAX_CYCLES = 4000;
    localparam logic [31:0] MEM_PATTERN = 32'h5A3C_96E1;

    logic        clk;
    logic        resetn;
    logic        valid;
    cpu_req_t    req;
    logic        addr_ok;
    logic        data_ok;
    logic [31:0] rdata;
    logic        rd_req;
    mem_rd_req_t rd;
    logic        rd_rdy;
    logic        ret_valid;
    logic        ret_last;
    logic [31:0] ret_data;
    logic        wr_req;
    mem_wr_req_t wr;
    logic        wr_rdy;

    int          errors;
    int          cycles;
    int          rd_count;
    int          wr_count;
    mem_rd_req_t last_rd;
    mem_wr_req_t last_wr;
    logic [15:0] lfsr;
    logic        rr_ptr;

    // memory contents and the expected cpu view
    logic [31:0] mem_words [logic [29:0]];
    logic [31:0] ref_mem [logic [29:0]];

    cache i_cache (
        .clk(clk), .resetn(resetn), .valid(valid), .req(req),
        .addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata),
        .rd_req(rd_req), .rd(rd), .rd_rdy(rd_rdy),
        .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data),
        .wr_req(wr_req), .wr(wr), .wr_rdy(wr_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    `include "cache_tb_tasks.svh"

    // memory responder serving one transfer at a time
    initial begin
        forever begin
            @(negedge clk);
            if (rd_req) begin
                serve_read();
            end else if (wr_req) begin
                serve_write();
            end
        end
    end

    initial begin
        errors    = 0;
        cycles    = 0;
        rd_count  = 0;
        wr_count  = 0;
        lfsr      = 16'd18;
        rr_ptr    = 1'b0;
        resetn    = 1'b0;
        valid     = 1'b0;
        req       = '0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;

        reset_outputs();
        read_miss_then_hit();
        write_hit_merge();
        dirty_eviction();
        uncached_access();

        repeat (4) @(posedge clk);
        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== verilog/cache.sv ====
`timescale 1ns/1ps
`include "cache_params.svh"

module cache (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   valid,
    input  cache_pkg::cpu_req_t    req,
    output logic                   addr_ok,
    output logic                   data_ok,
    output logic [31:0]            rdata,
    output logic                   rd_req,
    output cache_pkg::mem_rd_req_t rd,
    input  logic                   rd_rdy,
    input  logic                   ret_valid,
    input  logic                   ret_last,
    input  logic [31:0]            ret_data,
    output logic                   wr_req,
    output cache_pkg::mem_wr_req_t wr,
    input  logic                   wr_rdy
);
    import cache_pkg::*;

    cpu_req_t                                       req_q;
    logic [`CACHE_INDEX_WIDTH-1:0]                  rd_index;
    logic                                           we;
    logic                                           we_way;
    logic [`CACHE_INDEX_WIDTH-1:0]                  wr_index;
    line_meta_t                                     wr_meta;
    logic [`CACHE_LINE_WIDTH-1:0]                   wr_line;
    line_meta_t [`CACHE_WAYS-1:0]                   meta;
    logic [`CACHE_WAYS-1:0][`CACHE_LINE_WIDTH-1:0]  line;
    logic                                           hit;
    logic                                           hit_way;
    logic [31:0]                                    rd_word;
    logic [`CACHE_LINE_WIDTH-1:0]                   merged_line;
    logic [`CACHE_LINE_WIDTH-1:0]                   fill_line;
    logic                                           fill_done;

    cache_ctrl i_ctrl (
        .clk(clk), .resetn(resetn), .valid(valid), .req(req),
        .addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata), .req_q(req_q),
        .hit(hit), .hit_way(hit_way), .rd_word(rd_word), .merged_line(merged_line),
        .meta(meta), .line(line), .fill_done(fill_done),
        .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data),
        .rd_index(rd_index), .we(we), .we_way(we_way), .wr_index(wr_index),
        .wr_meta(wr_meta), .wr_line(wr_line),
        .rd_req(rd_req), .rd(rd), .rd_rdy(rd_rdy),
        .wr_req(wr_req), .wr(wr), .wr_rdy(wr_rdy)
    );

    cache_way_store i_store (
        .clk(clk), .resetn(resetn), .rd_index(rd_index),
        .we(we), .we_way(we_way), .wr_index(wr_index),
        .wr_meta(wr_meta), .wr_line(wr_line),
        .meta(meta), .line(line)
    );

    cache_hit_select i_hit_select (
        .clk(clk), .resetn(resetn), .req_q(req_q),
        .meta(meta), .line(line), .fill_line(fill_line),
        .hit(hit), .hit_way(hit_way), .rd_word(rd_word), .merged_line(merged_line)
    );

    cache_refill_buffer i_refill (
        .clk(clk), .resetn(resetn),
        .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data),
        .fill_line(fill_line), .fill_done(fill_done)
    );

endmodule

// ==== verilog/cache_ctrl.sv ====
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_ctrl (
    input  logic                                          clk,
    input  logic                                          resetn,
    input  logic                                          valid,
    input  cache_pkg::cpu_req_t                           req,
    output logic                                          addr_ok,
    output logic                                          data_ok,
    output logic [31:0]                                   rdata,
    output cache_pkg::cpu_req_t                           req_q,
    input  logic                                          hit,
    input  logic                                          hit_way,
    input  logic [31:0]                                   rd_word,
    input  logic [`CACHE_LINE_WIDTH-1:0]                  merged_line,
    input  cache_pkg::line_meta_t [`CACHE_WAYS-1:0]       meta,
    input  logic [`CACHE_WAYS-1:0][`CACHE_LINE_WIDTH-1:0] line,
    input  logic                                          fill_done,
    input  logic                                          ret_valid,
    input  logic                                          ret_last,
    input  logic [31:0]                                   ret_data,
    output logic [`CACHE_INDEX_WIDTH-1:0]                 rd_index,
    output logic                                          we,
    output logic                                          we_way,
    output logic [`CACHE_INDEX_WIDTH-1:0]                 wr_index,
    output cache_pkg::line_meta_t                         wr_meta,
    output logic [`CACHE_LINE_WIDTH-1:0]                  wr_line,
    output logic                                          rd_req,
    output cache_pkg::mem_rd_req_t                        rd,
    input  logic                                          rd_rdy,
    output logic                                          wr_req,
    output cache_pkg::mem_wr_req_t                        wr,
    input  logic                                          wr_rdy
);
    import cache_pkg::*;

    main_state_e                  state_q;
    main_state_e                  state_d;
    logic                         victim_q;
    line_meta_t                   vic_meta_q;
    logic [`CACHE_LINE_WIDTH-1:0] vic_line_q;
    logic                         rd_sent_q;
    logic                         cached;
    logic                         is_write;
    logic                         hit_write;
    logic                         refill_done;
    logic                         unc_rd_done;
    logic                         unc_wr_done;

    assign cached      = !req_q.uncached;
    assign is_write    = (req_q.op == OP_WRITE);
    assign hit_write   = (state_q == ST_LOOKUP) && cached && hit && is_write;
    assign refill_done = (state_q == ST_REFILL) && cached && fill_done;
    assign unc_rd_done = (state_q == ST_REFILL) && !cached && ret_valid && ret_last;
    assign unc_wr_done = (state_q == ST_REPLACE) && !cached && wr_rdy;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (valid) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                // uncached requests bypass the tag check
                if (!cached) begin
                    state_d = is_write ? ST_REPLACE : ST_REFILL;
                end else if (hit) begin
                    state_d = ST_IDLE;
                end else begin
                    state_d = ST_MISS;
                end
            end
            ST_MISS: begin
                state_d = (vic_meta_q.valid && vic_meta_q.dirty) ? ST_REPLACE : ST_REFILL;
            end
            ST_REPLACE: begin
                if (wr_rdy) begin
                    state_d = cached ? ST_REFILL : ST_IDLE;
                end
            end
            ST_REFILL: begin
                if (refill_done || unc_rd_done) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q   <= ST_IDLE;
            victim_q  <= 1'b0;
            rd_sent_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // one global round-robin pointer
            if (refill_done) begin
                victim_q <= ~victim_q;
            end
            if (state_q != ST_REFILL) begin
                rd_sent_q <= 1'b0;
            end else if (rd_req && rd_rdy) begin
                rd_sent_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (addr_ok && valid) begin
            req_q <= req;
        end
        // snapshot the victim before the set is overwritten
        if (state_q == ST_LOOKUP) begin
            vic_meta_q <= meta[victim_q];
            vic_line_q <= line[victim_q];
        end
    end

    assign addr_ok = (state_q == ST_IDLE);
    assign data_ok = ((state_q == ST_LOOKUP) && cached && hit) || refill_done
                     || unc_rd_done || unc_wr_done;
    assign rdata   = cached ? rd_word : ret_data;

    // store read follows the incoming request while idle
    assign rd_index = (state_q == ST_IDLE) ? req.index : req_q.index;

    assign we       = hit_write || refill_done;
    assign we_way   = (state_q == ST_LOOKUP) ? hit_way : victim_q;
    assign wr_index = req_q.index;
    assign wr_line  = merged_line;

    always_comb begin
        wr_meta.valid = 1'b1;
        wr_meta.dirty = is_write;
        wr_meta.tag   = req_q.tag;
    end

    assign rd_req   = (state_q == ST_REFILL) && !rd_sent_q;
    assign rd.xtype = cached ? XFER_LINE : xfer_type_e'({1'b0, req_q.size});
    assign rd.addr  = cached ? {req_q.tag, req_q.index, {`CACHE_OFFSET_WIDTH{1'b0}}}
                             : {req_q.tag, req_q.index, req_q.offset};

    // write-back of the victim or a single uncached store
    assign wr_req   = (state_q == ST_REPLACE);
    assign wr.xtype = cached ? XFER_LINE : xfer_type_e'({1'b0, req_q.size});
    assign wr.addr  = cached ? {vic_meta_q.tag, req_q.index, {`CACHE_OFFSET_WIDTH{1'b0}}}
                             : {req_q.tag, req_q.index, req_q.offset};
    assign wr.wstrb = cached ? 4'b1111 : req_q.wstrb;
    assign wr.data  = cached ? vic_line_q
                             : {{(`CACHE_LINE_WIDTH-32){1'b0}}, req_q.wdata};

    assert property (@(posedge clk) disable iff (!resetn) !(rd_req && wr_req));

    // the read request holds still while memory stalls
    assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd));

endmodule

// ==== verilog/cache_hit_select.sv ====
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_hit_select (
    input  logic                                          clk,
    input  logic                                          resetn,
    input  cache_pkg::cpu_req_t                           req_q,
    input  cache_pkg::line_meta_t [`CACHE_WAYS-1:0]       meta,
    input  logic [`CACHE_WAYS-1:0][`CACHE_LINE_WIDTH-1:0] line,
    input  logic [`CACHE_LINE_WIDTH-1:0]                  fill_line,
    output logic                                          hit,
    output logic                                          hit_way,
    output logic [31:0]                                   rd_word,
    output logic [`CACHE_LINE_WIDTH-1:0]                  merged_line
);
    import cache_pkg::*;

    logic [`CACHE_WAYS-1:0]       hit_vec;
    logic [`CACHE_LINE_WIDTH-1:0] sel_line;
    logic [2:0]                   word_sel;

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hit_vec[w] = meta[w].valid && (meta[w].tag == req_q.tag);
        end
    end

    assign hit     = |hit_vec;
    assign hit_way = hit_vec[1];

    // on a miss the line comes from the refill buffer
    assign sel_line = hit ? line[hit_way] : fill_line;

    // word within the line
    assign word_sel = req_q.offset[`CACHE_OFFSET_WIDTH-1:2];
    assign rd_word  = sel_line[word_sel*32 +: 32];

    // only the bytes of this store land in the line
    always_comb begin
        merged_line = sel_line;
        if (req_q.op == OP_WRITE) begin
            for (int b = 0; b < 4; b++) begin
                if (req_q.wstrb[b]) begin
                    merged_line[word_sel*32 + b*8 +: 8] = req_q.wdata[b*8 +: 8];
                end
            end
        end
    end

    // refills only target missing tags, so a set never holds one tag twice
    assert property (@(posedge clk) disable iff (!resetn)
        !$isunknown(hit_vec) |-> $onehot0(hit_vec));

endmodule

// ==== verilog/cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// address split is tag, index, byte offset
`define CACHE_TAG_WIDTH 20
`define CACHE_INDEX_WIDTH 7
`define CACHE_OFFSET_WIDTH 5

// sets per way
`define CACHE_SETS 128

// 32-byte line as eight 32-bit words
`define CACHE_LINE_WORDS 8
`define CACHE_LINE_WIDTH 256

// two-way set associative
`define CACHE_WAYS 2

`endif

// ==== verilog/cache_pkg.sv ====
`include "cache_params.svh"

package cache_pkg;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cache_op_e;

    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_LOOKUP  = 3'd1,
        ST_MISS    = 3'd2,
        ST_REPLACE = 3'd3,
        ST_REFILL  = 3'd4
    } main_state_e;

    // low three encodings match the cpu size field
    typedef enum logic [2:0] {
        XFER_BYTE = 3'b000,
        XFER_HALF = 3'b001,
        XFER_WORD = 3'b010,
        XFER_LINE = 3'b100
    } xfer_type_e;

    typedef struct packed {
        cache_op_e                      op;
        logic                           uncached;
        logic [1:0]                     size;
        logic [`CACHE_TAG_WIDTH-1:0]    tag;
        logic [`CACHE_INDEX_WIDTH-1:0]  index;
        logic [`CACHE_OFFSET_WIDTH-1:0] offset;
        logic [3:0]                     wstrb;
        logic [31:0]                    wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                        valid;
        logic                        dirty;
        logic [`CACHE_TAG_WIDTH-1:0] tag;
    } line_meta_t;

    typedef struct packed {
        xfer_type_e  xtype;
        logic [31:0] addr;
    } mem_rd_req_t;

    typedef struct packed {
        xfer_type_e                   xtype;
        logic [31:0]                  addr;
        logic [3:0]                   wstrb;
        logic [`CACHE_LINE_WIDTH-1:0] data;
    } mem_wr_req_t;

endpackage

// ==== verilog/cache_refill_buffer.sv ====
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_refill_buffer (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         ret_valid,
    input  logic                         ret_last,
    input  logic [31:0]                  ret_data,
    output logic [`CACHE_LINE_WIDTH-1:0] fill_line,
    output logic                         fill_done
);

    // beats come lowest word first
    logic [2:0] beat_cnt;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat_cnt  <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= ret_valid && ret_last;
            if (ret_valid) begin
                if (ret_last) begin
                    beat_cnt <= '0;
                end else begin
                    beat_cnt <= beat_cnt + 3'd1;
                end
            end
        end
    end

    // each beat drops into its own word slot
    always_ff @(posedge clk) begin
        if (ret_valid) begin
            fill_line[beat_cnt*32 +: 32] <= ret_data;
        end
    end

endmodule

// ==== verilog/cache_way_store.sv ====
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_way_store (
    input  logic                                          clk,
    input  logic                                          resetn,
    input  logic [`CACHE_INDEX_WIDTH-1:0]                 rd_index,
    input  logic                                          we,
    input  logic                                          we_way,
    input  logic [`CACHE_INDEX_WIDTH-1:0]                 wr_index,
    input  cache_pkg::line_meta_t                         wr_meta,
    input  logic [`CACHE_LINE_WIDTH-1:0]                  wr_line,
    output cache_pkg::line_meta_t [`CACHE_WAYS-1:0]       meta,
    output logic [`CACHE_WAYS-1:0][`CACHE_LINE_WIDTH-1:0] line
);

    // valid bits cleared by reset
    logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] valid_q;
    logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] dirty_q;

    logic [`CACHE_TAG_WIDTH-1:0]  tag_q  [`CACHE_WAYS][`CACHE_SETS];
    logic [`CACHE_LINE_WIDTH-1:0] data_q [`CACHE_WAYS][`CACHE_SETS];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= '0;
        end else if (we) begin
            valid_q[we_way][wr_index] <= wr_meta.valid;
        end
    end

    // single write port updating one way per cycle
    always_ff @(posedge clk) begin
        if (we) begin
            dirty_q[we_way][wr_index] <= wr_meta.dirty;
            tag_q[we_way][wr_index]   <= wr_meta.tag;
            data_q[we_way][wr_index]  <= wr_line;
        end
    end

    // registered read of one set from both ways
    always_ff @(posedge clk) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            meta[w].valid <= valid_q[w][rd_index];
            meta[w].dirty <= dirty_q[w][rd_index];
            meta[w].tag   <= tag_q[w][rd_index];
            line[w]       <= data_q[w][rd_index];
        end
    end

    // a line installed as valid must carry a known tag from the controller
    assert property (@(posedge clk) disable iff (!resetn)
        we && wr_meta.valid |-> !$isunknown(wr_meta.tag));

endmodule
